// ==== compile.f ====
+incdir+.
cart_pkg.sv
rom_mapper.sv
bsram_mapper.sv
msu_regs.sv
cart_top.sv
tb_checker.sv
tb_cart.sv

// ==== tb_cart.sv ====
`include "cart_cfg.svh"

module tb_cart;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles   = 16;
	localparam int run_cycles     = 2000;
	localparam int block_cycles   = 200;
	localparam int timeout_cycles = run_cycles + run_cycles / 4;
	localparam logic [15:0] msu_base = `MSU_BASE;

	logic                      mclk, arst_n, sysclkf_ce;
	logic [`CART_ADDR_W-1:0]   ca, rom_mask, ram_mask, rom_addr;
	logic                      cpurd_n, cpuwr_n, romsel_n;
	logic [`BYTE_W-1:0]        cpu_do, cpu_di, rom_type, bsram_d, bsram_q, volume;
	logic [`ROM_DATA_W-1:0]    rom_q;
	logic                      rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n;
	logic [`BSRAM_ADDR_W-1:0]  bsram_addr;
	logic                      msu_enable, track_request, track_mounting, track_missing;
	logic                      audio_stop, audio_repeat, audio_playing;
	logic [`TRACK_W-1:0]       track_num;
	int                        check_count, err_count;
	int                        cycle_count = 0;
	integer                    seed;

	logic [`ROM_DATA_W-1:0]    rom_mem [0:65535];
	logic [`BYTE_W-1:0]        sram_mem [0:65535];

	cart_top u_dut (.*);

	tb_checker u_chk (.*);

	initial begin
		mclk = 1'b0;
		forever #10 mclk = ~mclk;
	end

	// the memories answer combinationally, like the asynchronous parts on a cartridge.
	assign rom_q   = rom_mem[rom_addr[15:0]];
	assign bsram_q = sram_mem[bsram_addr[15:0]];

	always @(posedge mclk) begin
		if (!bsram_we_n) begin
			sram_mem[bsram_addr[15:0]] <= bsram_d;
		end
	end

	always @(posedge mclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run did not finish within %0d clock cycles", timeout_cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	task automatic configure_block();
		logic [31:0] r;
		r = next_rand();
		rom_type       = r[7:0];
		rom_mask       = r[8] ? 24'h3FFFFF : 24'h0FFFFF;
		msu_enable     = r[9];
		track_mounting = r[10];
		track_missing  = r[11];
		case (r[13:12])
			2'd0: ram_mask = 24'h000000;
			2'd1: ram_mask = 24'h0007FF;
			2'd2: ram_mask = 24'h001FFF;
			default: ram_mask = 24'h00FFFF;
		endcase
	endtask

	task automatic drive_bus_cycle();
		logic [31:0] pick;
		logic [31:0] r;
		pick     = next_rand() % 100;
		r        = next_rand();
		ca       = r[23:0];
		cpu_do   = r[31:24];
		romsel_n = 1'b1;
		cpurd_n  = 1'b1;
		cpuwr_n  = 1'b1;
		r        = next_rand();
		if (pick < 35) begin
			ca[15]   = 1'b1;
			romsel_n = 1'b0;
			cpurd_n  = 1'b0;
		end else if (pick < 60) begin
			// a small set of save RAM locations, so reads often hit earlier writes.
			ca[14:5] = {r[0], 9'd0};
			if (rom_type[1:0] == 2'd1 || rom_type[1:0] == 2'd2) begin
				ca[23:16] = {r[1], 2'b01, 4'd0, r[2]};
				ca[15:13] = 3'b011;
			end else begin
				ca[23:16] = {r[1], 3'b111, 3'd0, r[2]};
				ca[15]    = 1'b0;
				romsel_n  = 1'b0;
			end
			cpurd_n = r[3];
			cpuwr_n = ~r[3];
		end else if (pick < 85) begin
			ca[15:3] = msu_base[15:3];
			ca[22]   = (pick >= 80);
			romsel_n = r[4];
			cpurd_n  = r[5];
			cpuwr_n  = ~r[5];
		end
	endtask

	initial begin : stimulus
		logic [31:0] fill;
		seed = 66677;
		for (int i = 0; i < 65536; i++) begin
			fill        = next_rand();
			rom_mem[i]  = fill[15:0];
			sram_mem[i] = fill[23:16];
		end
		arst_n         = 1'b0;
		sysclkf_ce     = 1'b0;
		ca             = '0;
		cpurd_n        = 1'b1;
		cpuwr_n        = 1'b1;
		romsel_n       = 1'b1;
		cpu_do         = '0;
		rom_type       = '0;
		rom_mask       = '1;
		ram_mask       = '0;
		msu_enable     = 1'b0;
		track_mounting = 1'b0;
		track_missing  = 1'b0;
		audio_stop     = 1'b0;
		repeat (reset_cycles) @(posedge mclk);
		@(negedge mclk);
		arst_n = 1'b1;
		// each bus cycle is two mclk cycles, with the CPU enable on the second.
		for (int cyc = 0; cyc < run_cycles; cyc += 2) begin
			if (cyc % block_cycles == 0) begin
				configure_block();
			end
			drive_bus_cycle();
			sysclkf_ce = 1'b0;
			audio_stop = (next_rand() % 32) == 0;
			@(negedge mclk);
			sysclkf_ce = 1'b1;
			audio_stop = (next_rand() % 32) == 0;
			@(negedge mclk);
		end
		cpurd_n    = 1'b1;
		cpuwr_n    = 1'b1;
		romsel_n   = 1'b1;
		sysclkf_ce = 1'b0;
		audio_stop = 1'b0;
		repeat (2) @(negedge mclk);
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== tb_checker.sv ====
`include "cart_cfg.svh"

module tb_checker (
	input  logic                      mclk,
	input  logic                      arst_n,
	input  logic                      sysclkf_ce,
	input  logic [`CART_ADDR_W-1:0]   ca,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  logic                      romsel_n,
	input  logic [`BYTE_W-1:0]        cpu_do,
	input  logic [`BYTE_W-1:0]        cpu_di,
	input  logic [`BYTE_W-1:0]        rom_type,
	input  logic [`CART_ADDR_W-1:0]   rom_mask,
	input  logic [`CART_ADDR_W-1:0]   ram_mask,
	input  logic [`CART_ADDR_W-1:0]   rom_addr,
	input  logic [`ROM_DATA_W-1:0]    rom_q,
	input  logic                      rom_ce_n,
	input  logic                      rom_oe_n,
	input  logic [`BSRAM_ADDR_W-1:0]  bsram_addr,
	input  logic [`BYTE_W-1:0]        bsram_d,
	input  logic [`BYTE_W-1:0]        bsram_q,
	input  logic                      bsram_ce_n,
	input  logic                      bsram_oe_n,
	input  logic                      bsram_we_n,
	input  logic                      msu_enable,
	input  logic [`TRACK_W-1:0]       track_num,
	input  logic                      track_request,
	input  logic                      track_mounting,
	input  logic                      track_missing,
	input  logic [`BYTE_W-1:0]        volume,
	input  logic                      audio_stop,
	input  logic                      audio_repeat,
	input  logic                      audio_playing,
	output int                        check_count,
	output int                        err_count
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] msu_base = `MSU_BASE;

	logic [7:0]   bank, msu_byte, exp_cpu_di, m_volume;
	logic         is_hirom, is_exhirom, rom_acc, bsel, msel;
	logic [23:0]  exp_rom_addr;
	logic [19:0]  exp_bsram_addr;
	logic [15:0]  m_track;
	logic         m_request, m_playing, m_repeat;

	// bit 8 marks a save RAM byte that the CPU has written.
	logic [8:0]   shadow [0:(1 << `BSRAM_ADDR_W) - 1];

	initial begin
		check_count = 0;
		err_count   = 0;
	end

	function automatic logic [7:0] ident_byte(input logic [2:0] ofs);
		case (ofs)
			3'd2: return "S";
			3'd3: return "-";
			3'd4: return "M";
			3'd5: return "S";
			3'd6: return "U";
			default: return "1";
		endcase
	endfunction

	task automatic compare_field(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] t=%0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic decode_bus();
		bank       = ca[23:16];
		is_hirom   = rom_type[1:0] == 2'd1;
		is_exhirom = rom_type[1:0] == 2'd2;
		if (is_exhirom) begin
			exp_rom_addr = {1'b0, ~bank[7], bank[5:0], ca[15:0]};
		end else if (is_hirom) begin
			exp_rom_addr = {2'b00, bank[5:0], ca[15:0]};
		end else begin
			exp_rom_addr = {2'b00, bank[6:0], ca[14:0]};
		end
		exp_rom_addr = exp_rom_addr & rom_mask;
		if (is_hirom || is_exhirom) begin
			bsel           = !bank[6] && bank[5] && ca[15:13] == 3'b011;
			exp_bsram_addr = {2'b00, bank[4:0], ca[12:0]};
		end else begin
			bsel = !romsel_n && bank[6:4] == 3'b111 && bank[3:0] != 4'd14
				&& bank[3:0] != 4'd15 && !ca[15];
			exp_bsram_addr = {1'b0, bank[3:0], ca[14:0]};
		end
		bsel           = bsel && ram_mask != 0;
		exp_bsram_addr = exp_bsram_addr & ram_mask[19:0];
		rom_acc        = !romsel_n && !bsel;
		msel           = msu_enable && !bank[6] && ca[15:3] == msu_base[15:3];
	endtask

	task automatic update_msu();
		m_request = 1'b0;
		if (audio_stop) begin
			m_playing = 1'b0;
		end
		if (msel && !cpuwr_n && sysclkf_ce) begin
			case (ca[2:0])
				3'd4: m_track[7:0] = cpu_do;
				3'd5: begin
					m_track[15:8] = cpu_do;
					m_playing     = 1'b0;
					m_request     = 1'b1;
				end
				3'd6: m_volume = cpu_do;
				3'd7: begin
					m_playing = cpu_do[0];
					m_repeat  = cpu_do[1];
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic compare_outputs();
		case (ca[2:0])
			3'd0: msu_byte = {1'b0, track_mounting, m_repeat, m_playing, track_missing,
				`MSU_VERSION};
			3'd1: msu_byte = 8'h00;
			default: msu_byte = ident_byte(ca[2:0]);
		endcase
		if (msel) begin
			exp_cpu_di = msu_byte;
		end else if (bsel) begin
			exp_cpu_di = bsram_q;
		end else if (rom_acc) begin
			exp_cpu_di = ca[0] ? rom_q[15:8] : rom_q[7:0];
		end else begin
			exp_cpu_di = 8'h00;
		end
		compare_field("rom_addr", rom_addr, exp_rom_addr);
		compare_field("rom_ce_n", rom_ce_n, !rom_acc);
		compare_field("rom_oe_n", rom_oe_n, rom_acc ? cpurd_n : 1'b1);
		compare_field("bsram_addr", bsram_addr, exp_bsram_addr);
		compare_field("bsram_ce_n", bsram_ce_n, !bsel);
		compare_field("bsram_oe_n", bsram_oe_n, bsel ? cpurd_n : 1'b1);
		compare_field("bsram_we_n", bsram_we_n, bsel ? cpuwr_n : 1'b1);
		compare_field("bsram_d", bsram_d, cpu_do);
		compare_field("cpu_di", cpu_di, exp_cpu_di);
		compare_field("track_num", track_num, m_track);
		compare_field("volume", volume, m_volume);
		compare_field("track_request", track_request, m_request);
		compare_field("audio_playing", audio_playing, m_playing);
		compare_field("audio_repeat", audio_repeat, m_repeat);
		if (ram_mask == 0) begin
			compare_field("save RAM strobes, zero mask", {bsram_ce_n, bsram_oe_n, bsram_we_n},
				3'b111);
		end
		if (bsel && !cpuwr_n) begin
			shadow[exp_bsram_addr] = {1'b1, cpu_do};
		end
		if (bsel && !cpurd_n && shadow[exp_bsram_addr][8] === 1'b1) begin
			compare_field("save RAM readback", cpu_di, shadow[exp_bsram_addr][7:0]);
		end
	endtask

	// sampled just after the rising edge, once the registers and the bus have settled.
	always @(posedge mclk) begin
		#1;
		if (!arst_n) begin
			m_track   = '0;
			m_volume  = '0;
			m_request = 1'b0;
			m_playing = 1'b0;
			m_repeat  = 1'b0;
		end else begin
			decode_bus();
			update_msu();
			compare_outputs();
		end
	end

endmodule

// ==== cart_top.sv ====
`include "cart_cfg.svh"

module cart_top (
	input  logic                      mclk,
	input  logic                      arst_n,
	input  logic                      sysclkf_ce,

	input  logic [`CART_ADDR_W-1:0]   ca,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  logic                      romsel_n,
	input  logic [`BYTE_W-1:0]        cpu_do,
	output logic [`BYTE_W-1:0]        cpu_di,

	input  logic [`BYTE_W-1:0]        rom_type,
	input  logic [`CART_ADDR_W-1:0]   rom_mask,
	input  logic [`CART_ADDR_W-1:0]   ram_mask,

	output logic [`CART_ADDR_W-1:0]   rom_addr,
	input  logic [`ROM_DATA_W-1:0]    rom_q,
	output logic                      rom_ce_n,
	output logic                      rom_oe_n,

	output logic [`BSRAM_ADDR_W-1:0]  bsram_addr,
	output logic [`BYTE_W-1:0]        bsram_d,
	input  logic [`BYTE_W-1:0]        bsram_q,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n,

	input  logic                      msu_enable,
	output logic [`TRACK_W-1:0]       track_num,
	output logic                      track_request,
	input  logic                      track_mounting,
	input  logic                      track_missing,
	output logic [`BYTE_W-1:0]        volume,
	input  logic                      audio_stop,
	output logic                      audio_repeat,
	output logic                      audio_playing
);

	logic                bsram_sel;
	logic [`BYTE_W-1:0]  map_di;

	rom_mapper u_rom_mapper (
		.ca         (ca),
		.romsel_n   (romsel_n),
		.cpurd_n    (cpurd_n),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.rom_q      (rom_q),
		.bsram_sel  (bsram_sel),
		.bsram_q    (bsram_q),
		.rom_addr   (rom_addr),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.map_di     (map_di)
	);

	bsram_mapper u_bsram_mapper (
		.ca          (ca),
		.romsel_n    (romsel_n),
		.cpurd_n     (cpurd_n),
		.cpuwr_n     (cpuwr_n),
		.cpu_do      (cpu_do),
		.rom_type    (rom_type),
		.ram_mask    (ram_mask),
		.bsram_sel   (bsram_sel),
		.bsram_addr  (bsram_addr),
		.bsram_d     (bsram_d),
		.bsram_ce_n  (bsram_ce_n),
		.bsram_oe_n  (bsram_oe_n),
		.bsram_we_n  (bsram_we_n)
	);

	msu_regs u_msu_regs (
		.mclk            (mclk),
		.arst_n          (arst_n),
		.msu_enable      (msu_enable),
		.ca              (ca),
		.cpuwr_n         (cpuwr_n),
		.sysclkf_ce      (sysclkf_ce),
		.cpu_do          (cpu_do),
		.map_di          (map_di),
		.track_mounting  (track_mounting),
		.track_missing   (track_missing),
		.audio_stop      (audio_stop),
		.cpu_di          (cpu_di),
		.track_num       (track_num),
		.track_request   (track_request),
		.volume          (volume),
		.audio_playing   (audio_playing),
		.audio_repeat    (audio_repeat)
	);

endmodule

// ==== msu_regs.sv ====
`include "cart_cfg.svh"

module msu_regs (
	input  logic                     mclk,
	input  logic                     arst_n,
	input  logic                     msu_enable,
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic                     cpuwr_n,
	input  logic                     sysclkf_ce,
	input  logic [`BYTE_W-1:0]       cpu_do,
	input  logic [`BYTE_W-1:0]       map_di,
	input  logic                     track_mounting,
	input  logic                     track_missing,
	input  logic                     audio_stop,

	output logic [`BYTE_W-1:0]       cpu_di,
	output logic [`TRACK_W-1:0]      track_num,
	output logic                     track_request,
	output logic [`BYTE_W-1:0]       volume,
	output logic                     audio_playing,
	output logic                     audio_repeat
);

	import cart_pkg::*;

	localparam logic [15:0] msu_base = `MSU_BASE;

	// ident string read back at offsets 2 to 7 with the first character in the top byte.
	localparam logic [47:0] msu_ident = "S-MSU1";

	logic                msu_sel;
	logic                msu_wr;
	msu_reg_e            reg_ofs;
	logic [`BYTE_W-1:0]  msu_q;

	// the window repeats in every bank with bit 6 clear.
	assign msu_sel = msu_enable & ~ca[22] & (ca[15:3] == msu_base[15:3]);
	assign msu_wr  = msu_sel & ~cpuwr_n & sysclkf_ce;
	assign reg_ofs = msu_reg_e'(ca[`MSU_OFS_W-1:0]);

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			track_num     <= '0;
			track_request <= 1'b0;
			volume        <= '0;
			audio_playing <= 1'b0;
			audio_repeat  <= 1'b0;
		end else begin
			track_request <= 1'b0;

			// a control write in the same cycle overrides the stop pulse.
			if (audio_stop) begin
				audio_playing <= 1'b0;
			end

			if (msu_wr) begin
				case (reg_ofs)
					msu_track_lo: begin
						track_num[7:0] <= cpu_do;
					end
					msu_track_hi: begin
						// the high byte completes the track number and starts the load.
						track_num[15:8] <= cpu_do;
						audio_playing   <= 1'b0;
						track_request   <= 1'b1;
					end
					msu_volume: begin
						volume <= cpu_do;
					end
					msu_control: begin
						audio_playing <= cpu_do[0];
						audio_repeat  <= cpu_do[1];
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (reg_ofs)
			msu_status: begin
				msu_q = {1'b0, track_mounting, audio_repeat, audio_playing,
					track_missing, `MSU_VERSION};
			end
			msu_reserved: begin
				msu_q = '0;
			end
			default: begin
				msu_q = msu_ident[8 * (7 - int'(ca[`MSU_OFS_W-1:0])) +: 8];
			end
		endcase
	end

	// MSU reads replace whatever the cartridge returns.
	assign cpu_di = msu_sel ? msu_q : map_di;

	// sysclkf_ce is never high on two mclk edges in a row, so each
	// high-byte write from the CPU gives a single request cycle.
	a_track_req_pulse: assert property (
		@(posedge mclk) disable iff (!arst_n) track_request |=> !track_request
	) else $error("track request held for more than one cycle");

	// a register write must carry known data from the CPU.
	a_wr_data_known: assert property (
		@(posedge mclk) disable iff (!arst_n) msu_wr |-> !$isunknown(cpu_do)
	) else $error("MSU register write with unknown data");

endmodule

// ==== bsram_mapper.sv ====
`include "cart_cfg.svh"

module bsram_mapper (
	input  logic [`CART_ADDR_W-1:0]   ca,
	input  logic                      romsel_n,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  logic [`BYTE_W-1:0]        cpu_do,
	input  logic [`BYTE_W-1:0]        rom_type,
	input  logic [`CART_ADDR_W-1:0]   ram_mask,

	output logic                      bsram_sel,
	output logic [`BSRAM_ADDR_W-1:0]  bsram_addr,
	output logic [`BYTE_W-1:0]        bsram_d,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n
);

	import cart_pkg::*;

	map_type_e                 map_type;
	logic [`BYTE_W-1:0]        bank;
	logic                      window;
	logic [`BSRAM_ADDR_W-1:0]  bsram_addr_raw;

	assign map_type = decode_map_type(rom_type);
	assign bank     = ca[`CART_ADDR_W-1:`CART_ADDR_W-`BYTE_W];

	always_comb begin
		if (map_type == map_lorom) begin
			// the lower 32 KB of banks 70-7D and F0-FD.
			window = ~romsel_n & (bank[6:4] == 3'b111) & (bank[3:0] < 4'd14) & ~ca[15];
			bsram_addr_raw = {1'b0, bank[3:0], ca[14:0]};
		end else begin
			// 8 KB at 6000-7FFF in banks 20-3F and A0-BF.
			window = ~bank[6] & bank[5] & (ca[15:13] == 3'b011);
			bsram_addr_raw = {2'b00, bank[4:0], ca[12:0]};
		end
	end

	// a cartridge without save RAM has a zero mask.
	assign bsram_sel  = window & (|ram_mask);
	assign bsram_addr = bsram_addr_raw & ram_mask[`BSRAM_ADDR_W-1:0];
	assign bsram_d    = cpu_do;

	assign bsram_ce_n = ~bsram_sel;
	assign bsram_oe_n = bsram_sel ? cpurd_n : 1'b1;
	assign bsram_we_n = bsram_sel ? cpuwr_n : 1'b1;

endmodule

// ==== rom_mapper.sv ====
`include "cart_cfg.svh"

module rom_mapper (
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic                     romsel_n,
	input  logic                     cpurd_n,
	input  logic [`BYTE_W-1:0]       rom_type,
	input  logic [`CART_ADDR_W-1:0]  rom_mask,
	input  logic [`ROM_DATA_W-1:0]   rom_q,
	input  logic                     bsram_sel,
	input  logic [`BYTE_W-1:0]       bsram_q,

	output logic [`CART_ADDR_W-1:0]  rom_addr,
	output logic                     rom_ce_n,
	output logic                     rom_oe_n,
	output logic [`BYTE_W-1:0]       map_di
);

	import cart_pkg::*;

	map_type_e                map_type;
	logic [`BYTE_W-1:0]       bank;
	logic                     rom_access;
	logic [`CART_ADDR_W-1:0]  rom_addr_raw;
	logic [`BYTE_W-1:0]       rom_byte;

	assign map_type = decode_map_type(rom_type);
	assign bank     = ca[`CART_ADDR_W-1:`CART_ADDR_W-`BYTE_W];

	// the save RAM window takes priority over ROM inside the romsel range.
	assign rom_access = ~romsel_n & ~bsram_sel;

	always_comb begin
		case (map_type)
			map_hirom: begin
				rom_addr_raw = {2'b00, bank[5:0], ca[15:0]};
			end
			map_exhirom: begin
				// banks 00-7F map to the upper 4 MB, 80-FF to the lower.
				rom_addr_raw = {1'b0, ~bank[7], bank[5:0], ca[15:0]};
			end
			default: begin
				// A15 only selects the ROM half of each 32 KB page.
				rom_addr_raw = {2'b00, bank[6:0], ca[14:0]};
			end
		endcase
	end

	assign rom_addr = rom_addr_raw & rom_mask;

	assign rom_ce_n = ~rom_access;
	assign rom_oe_n = rom_access ? cpurd_n : 1'b1;

	// A0 picks the byte lane of the 16-bit ROM word.
	assign rom_byte = ca[0] ? rom_q[`ROM_DATA_W-1:`BYTE_W] : rom_q[`BYTE_W-1:0];

	always_comb begin
		if (bsram_sel) begin
			map_di = bsram_q;
		end else if (rom_access) begin
			map_di = rom_byte;
		end else begin
			map_di = '0;
		end
	end

endmodule

// ==== cart_pkg.sv ====
`include "cart_cfg.svh"

package cart_pkg;

	// cartridge layouts. Value 3 of the header field falls back to LoROM.
	typedef enum logic [1:0] {
		map_lorom   = 2'd0,
		map_hirom   = 2'd1,
		map_exhirom = 2'd2
	} map_type_e;

	// register offsets inside the MSU window.
	// offsets 2 to 7 also read back the ident string.
	typedef enum logic [`MSU_OFS_W-1:0] {
		msu_status   = 3'd0,
		msu_reserved = 3'd1,
		msu_ident_2  = 3'd2,
		msu_ident_3  = 3'd3,
		msu_track_lo = 3'd4,
		msu_track_hi = 3'd5,
		msu_volume   = 3'd6,
		msu_control  = 3'd7
	} msu_reg_e;

	function automatic map_type_e decode_map_type(input logic [`BYTE_W-1:0] rom_type);
		case (rom_type[1:0])
			2'd1: return map_hirom;
			2'd2: return map_exhirom;
			default: return map_lorom;
		endcase
	endfunction

endpackage

// ==== cart_cfg.svh ====
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// CPU bus and ROM address width, and the bank field sits in the top byte.
`define CART_ADDR_W 24

// the ROM is read a 16-bit word at a time.
`define ROM_DATA_W 16

// save RAM address width.
`define BSRAM_ADDR_W 20

// CPU data bus width.
`define BYTE_W 8

// eight MSU registers start at this address in banks with bit 6 clear.
`define MSU_BASE 16'h2000

// width of the MSU register offset.
`define MSU_OFS_W 3

// version field returned in the low bits of the MSU status byte.
`define MSU_VERSION 3'd1

// track numbers are written as two bytes.
`define TRACK_W 16

`endif
